// File: blake_types_pkg.sv
package blake_types_pkg;

   // one 32-bit word
   typedef logic [31:0] word_t;

   // word 0 is the leftmost word of a literal or concatenation
   typedef word_t [0:15] block_t;

   // chaining value, eight words
   typedef word_t [0:7] chain_t;

   // four G units, two pre-xored message words each
   typedef word_t [0:7] pair_t;

   typedef logic [63:0] counter_t;

   // half-round index; even is column, odd is diagonal
   typedef logic [4:0] hround_t;

endpackage

// File: blake_const_pkg.sv
package blake_const_pkg;

   import blake_types_pkg::*;

   // pi constants C0 .. C15
   localparam block_t BLAKE_C = {
      32'h243F6A88, 32'h85A308D3, 32'h13198A2E, 32'h03707344,
      32'hA4093822, 32'h299F31D0, 32'h082EFA98, 32'hEC4E6C89,
      32'h452821E6, 32'h38D01377, 32'hBE5466CF, 32'h34E90C6C,
      32'hC0AC29B7, 32'hC97C50DD, 32'h3F84D5B5, 32'hB5470917
   };

   // BLAKE-256 initial value
   localparam chain_t BLAKE_IV = {
      32'h6A09E667, 32'hBB67AE85, 32'h3C6EF372, 32'hA54FF53A,
      32'h510E527F, 32'h9B05688C, 32'h1F83D9AB, 32'h5BE0CD19
   };

   // one row per round, first entry in the top nibble
   localparam logic [0:9][0:15][3:0] SIGMA = {
      64'h0123_4567_89AB_CDEF,
      64'hEA48_9FD6_1C02_B753,
      64'hB8C0_52FD_AE36_7194,
      64'h7931_DCBE_265A_40F8,
      64'h9057_24AF_E1BC_683D,
      64'h2C6A_0B83_4D75_FE19,
      64'hC51F_ED4A_0763_928B,
      64'hDB7E_C139_50F4_862A,
      64'h6FE9_B308_C2D7_14A5,
      64'hA284_7615_FB9E_3CD0
   };

   // right rotations inside G
   localparam int ROT_A = 16;
   localparam int ROT_B = 12;
   localparam int ROT_C = 8;
   localparam int ROT_D = 7;

endpackage

// File: blake_g.sv
`timescale 1ns/1ps

module blake_g
   import blake_types_pkg::*;
   import blake_const_pkg::*;
(
   input  word_t a_i,
   input  word_t b_i,
   input  word_t c_i,
   input  word_t d_i,
   input  word_t m0_i,
   input  word_t m1_i,
   output word_t a_o,
   output word_t b_o,
   output word_t c_o,
   output word_t d_o
);

   function automatic word_t rotr(input word_t x, input int n);
      return (x >> n) | (x << (32 - n));
   endfunction

   word_t a0;
   word_t b0;
   word_t c0;
   word_t d0;

   // first half, message word already xored with its constant
   assign a0 = a_i + b_i + m0_i;
   assign d0 = rotr(d_i ^ a0, ROT_A);
   assign c0 = c_i + d0;
   assign b0 = rotr(b_i ^ c0, ROT_B);

   // second half
   assign a_o = a0 + b0 + m1_i;
   assign d_o = rotr(d0 ^ a_o, ROT_C);
   assign c_o = c0 + d_o;
   assign b_o = rotr(b0 ^ c_o, ROT_D);

endmodule

// File: blake_msg_sched.sv
`timescale 1ns/1ps

module blake_msg_sched
   import blake_types_pkg::*;
   import blake_const_pkg::*;
#(
   parameter int NUM_ROUNDS = 8
) (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    start_i,
   input  block_t  block_i,
   output logic    active_o,
   output hround_t half_o,
   output logic    last_o,
   output pair_t   msg_pair_o
);

   localparam hround_t LAST_HALF = hround_t'(2 * NUM_ROUNDS - 1);

   block_t     msg_q;
   hround_t    half_q;
   logic       active_q;
   logic [3:0] rnd;
   logic [3:0] sig_row;

   always_ff @(posedge clk) begin
      if (start_i) begin
         msg_q <= block_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active_q <= 1'b0;
         half_q   <= '0;
      end else if (start_i) begin
         active_q <= 1'b1;
         half_q   <= '0;
      end else if (active_q) begin
         if (last_o) begin
            active_q <= 1'b0;
            half_q   <= '0;
         end else begin
            half_q <= half_q + 1'b1;
         end
      end
   end

   assign active_o = active_q;
   assign half_o   = half_q;
   assign last_o   = active_q && (half_q == LAST_HALF);

   // rounds past nine wrap back onto the table
   assign rnd     = half_q[4:1];
   assign sig_row = (rnd >= 4'd10) ? rnd - 4'd10 : rnd;

   // diagonal half uses entries 8 to 15 of the row
   for (genvar j = 0; j < 4; j++) begin : g_pair
      logic [3:0] s0;
      logic [3:0] s1;

      assign s0 = SIGMA[sig_row][{half_q[0], 3'(2 * j)}];
      assign s1 = SIGMA[sig_row][{half_q[0], 3'(2 * j + 1)}];
      assign msg_pair_o[2 * j]     = msg_q[s0] ^ BLAKE_C[s1];
      assign msg_pair_o[2 * j + 1] = msg_q[s1] ^ BLAKE_C[s0];
   end

   // a new block must not arrive while the rounds are running
   a_start_idle : assert property (
      @(posedge clk) disable iff (!rst_n) start_i |-> !active_q
   ) else $error("start strobe while the core is busy");

endmodule

// File: blake_state_regs.sv
`timescale 1ns/1ps

module blake_state_regs
   import blake_types_pkg::*;
   import blake_const_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     start_i,
   input  logic     active_i,
   input  hround_t  half_i,
   input  pair_t    msg_pair_i,
   input  chain_t   chain_i,
   input  counter_t counter_i,
   output block_t   state_o
);

   block_t     v_q;
   block_t     v_nxt;
   logic       diag;
   word_t      cnt_hi;
   word_t      cnt_lo;
   logic [3:0] ib [4];
   logic [3:0] ic [4];
   logic [3:0] id [4];
   word_t      ga [4];
   word_t      gb [4];
   word_t      gc [4];
   word_t      gd [4];

   assign diag   = half_i[0];
   assign cnt_hi = counter_i[63:32];
   assign cnt_lo = counter_i[31:0];

   // column j is (j, 4+j, 8+j, 12+j), diagonals rotate each row by its depth
   always_comb begin
      for (int j = 0; j < 4; j++) begin
         ib[j] = diag ? 4'(4 + ((j + 1) % 4)) : 4'(4 + j);
         ic[j] = diag ? 4'(8 + ((j + 2) % 4)) : 4'(8 + j);
         id[j] = diag ? 4'(12 + ((j + 3) % 4)) : 4'(12 + j);
      end
   end

   for (genvar j = 0; j < 4; j++) begin : g_unit
      blake_g u_g (
         .a_i  (v_q[j]),
         .b_i  (v_q[ib[j]]),
         .c_i  (v_q[ic[j]]),
         .d_i  (v_q[id[j]]),
         .m0_i (msg_pair_i[2 * j]),
         .m1_i (msg_pair_i[2 * j + 1]),
         .a_o  (ga[j]),
         .b_o  (gb[j]),
         .c_o  (gc[j]),
         .d_o  (gd[j])
      );
   end

   // write results back to the words they came from
   always_comb begin
      v_nxt = v_q;
      for (int j = 0; j < 4; j++) begin
         v_nxt[j]     = ga[j];
         v_nxt[ib[j]] = gb[j];
         v_nxt[ic[j]] = gc[j];
         v_nxt[id[j]] = gd[j];
      end
   end

   always_ff @(posedge clk) begin
      if (start_i) begin
         v_q <= {chain_i,
                 BLAKE_C[0], BLAKE_C[1], BLAKE_C[2], BLAKE_C[3],
                 BLAKE_C[4] ^ cnt_hi, BLAKE_C[5] ^ cnt_hi,
                 BLAKE_C[6] ^ cnt_lo, BLAKE_C[7] ^ cnt_lo};
      end else if (active_i) begin
         v_q <= v_nxt;
      end
   end

   assign state_o = v_q;

   // a reload in mid-run would corrupt the state under the scheduler
   a_no_load_in_run : assert property (
      @(posedge clk) disable iff (!rst_n) !(start_i && active_i)
   ) else $error("state load during an active half-round");

endmodule

// File: blake_chain_hash.sv
`timescale 1ns/1ps

module blake_chain_hash
   import blake_types_pkg::*;
   import blake_const_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   init_i,
   input  logic   last_i,
   input  block_t state_i,
   output chain_t hash_o,
   output logic   done_o
);

   chain_t hash_q;
   chain_t ff_val;
   logic   ff_pend;
   logic   done_q;

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         ff_val[i] = hash_q[i] ^ state_i[i] ^ state_i[i + 8];
      end
   end

   // the state takes its last half-round on the edge that clears last_i
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ff_pend <= 1'b0;
         done_q  <= 1'b0;
         hash_q  <= '0;
      end else begin
         ff_pend <= last_i;
         done_q  <= ff_pend;
         if (init_i) begin
            hash_q <= BLAKE_IV;
         end else if (ff_pend) begin
            hash_q <= ff_val;
         end
      end
   end

   assign hash_o = hash_q;
   assign done_o = done_q;

   // init has to stay clear of the closing half-round and the feed-forward
   a_init_idle : assert property (
      @(posedge clk) disable iff (!rst_n) init_i |-> !(last_i || ff_pend)
   ) else $error("init strobe while a block is finishing");

endmodule

// File: blake_core_top.sv
`timescale 1ns/1ps

module blake_core_top
   import blake_types_pkg::*;
#(
   parameter int NUM_ROUNDS = 8
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     init_i,
   input  logic     start_i,
   input  block_t   block_i,
   input  counter_t counter_i,
   output logic     busy_o,
   output logic     done_o,
   output chain_t   hash_o
);

   logic    active;
   logic    last;
   hround_t half;
   pair_t   msg_pair;
   block_t  state;

   blake_msg_sched #(
      .NUM_ROUNDS (NUM_ROUNDS)
   ) u_sched (
      .clk        (clk),
      .rst_n      (rst_n),
      .start_i    (start_i),
      .block_i    (block_i),
      .active_o   (active),
      .half_o     (half),
      .last_o     (last),
      .msg_pair_o (msg_pair)
   );

   blake_state_regs u_state (
      .clk        (clk),
      .rst_n      (rst_n),
      .start_i    (start_i),
      .active_i   (active),
      .half_i     (half),
      .msg_pair_i (msg_pair),
      .chain_i    (hash_o),
      .counter_i  (counter_i),
      .state_o    (state)
   );

   blake_chain_hash u_chain (
      .clk     (clk),
      .rst_n   (rst_n),
      .init_i  (init_i),
      .last_i  (last),
      .state_i (state),
      .hash_o  (hash_o),
      .done_o  (done_o)
   );

   assign busy_o = active;

endmodule

// File: blake_ref_model.svh
`ifndef BLAKE_REF_MODEL_SVH
`define BLAKE_REF_MODEL_SVH

// standard BLAKE-256 initial value
localparam chain_t EXPECTED_IV = {
   32'h6A09E667, 32'hBB67AE85, 32'h3C6EF372, 32'hA54FF53A,
   32'h510E527F, 32'h9B05688C, 32'h1F83D9AB, 32'h5BE0CD19
};

function automatic word_t rotate_right(input word_t x, input int n);
   return (x >> n) | (x << (32 - n));
endfunction

// one G step on words a, b, c, d with pre-xored message words x and y
function automatic block_t apply_g(input block_t v, input int a, input int b, input int c,
                                   input int d, input word_t x, input word_t y);
   block_t w;
   w = v;
   w[a] = w[a] + w[b] + x;
   w[d] = rotate_right(w[d] ^ w[a], 16);
   w[c] = w[c] + w[d];
   w[b] = rotate_right(w[b] ^ w[c], 12);
   w[a] = w[a] + w[b] + y;
   w[d] = rotate_right(w[d] ^ w[a], 8);
   w[c] = w[c] + w[d];
   w[b] = rotate_right(w[b] ^ w[c], 7);
   return w;
endfunction

function automatic chain_t compress_block(input chain_t h, input block_t m, input counter_t t,
                                          input int rounds);
   // G0..G3 on columns, G4..G7 on diagonals
   int         qa [8] = '{0, 1, 2, 3, 0, 1, 2, 3};
   int         qb [8] = '{4, 5, 6, 7, 5, 6, 7, 4};
   int         qc [8] = '{8, 9, 10, 11, 10, 11, 8, 9};
   int         qd [8] = '{12, 13, 14, 15, 15, 12, 13, 14};
   block_t     v;
   chain_t     out;
   int         row;
   logic [3:0] s0;
   logic [3:0] s1;
   for (int w = 0; w < 8; w++) begin
      v[w]     = h[w];
      v[w + 8] = BLAKE_C[w];
   end
   v[12] = v[12] ^ t[63:32];
   v[13] = v[13] ^ t[63:32];
   v[14] = v[14] ^ t[31:0];
   v[15] = v[15] ^ t[31:0];
   for (int r = 0; r < rounds; r++) begin
      row = r % 10;
      for (int i = 0; i < 8; i++) begin
         s0 = SIGMA[row][2 * i];
         s1 = SIGMA[row][2 * i + 1];
         v  = apply_g(v, qa[i], qb[i], qc[i], qd[i], m[s0] ^ BLAKE_C[s1], m[s1] ^ BLAKE_C[s0]);
      end
   end
   for (int w = 0; w < 8; w++) begin
      out[w] = h[w] ^ v[w] ^ v[w + 8];
   end
   return out;
endfunction

`endif

// File: blake_tb.sv
`timescale 1ns/1ps

module blake_tb
   import blake_types_pkg::*;
   import blake_const_pkg::*;
();

   localparam int NUM_ROUNDS     = 8;
   localparam int NUM_ROWS       = 6;
   localparam int SEED           = 25339;
   localparam int TIMEOUT_CYCLES = NUM_ROWS * (2 * NUM_ROUNDS + 8) + 50;

   logic     clk;
   logic     rst_n;
   logic     init;
   logic     start;
   block_t   block;
   counter_t counter;
   logic     busy;
   logic     done;
   chain_t   hash;

   int value_errors    = 0;
   int protocol_errors = 0;
   int cycles          = 0;

   // stimulus table
   string    names [NUM_ROWS] = '{"first_init", "chain_a", "chain_b",
                                   "reinit", "chain_c", "last_init"};
   bit       init_tab [NUM_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
   block_t   blocks [NUM_ROWS];
   counter_t ctrs [NUM_ROWS];
   chain_t   expected [NUM_ROWS];

   `include "blake_ref_model.svh"

   blake_core_top #(
      .NUM_ROUNDS (NUM_ROUNDS)
   ) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .init_i    (init),
      .start_i   (start),
      .block_i   (block),
      .counter_i (counter),
      .busy_o    (busy),
      .done_o    (done),
      .hash_o    (hash)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, done_o never came back", cycles);
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      $display("test failed");
      $finish;
   end

   task automatic check_hash(input string name, input chain_t exp, input chain_t act);
      assert (act === exp) else begin
         value_errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      assert (act == exp) else begin
         value_errors++;
         $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      assert (act === exp) else begin
         value_errors++;
         $display("** Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic run_row(input int idx);
      int edges;
      if (init_tab[idx]) begin
         @(posedge clk);
         #2 init = 1'b1;
         @(posedge clk);
         #2 init = 1'b0;
         @(negedge clk);
         check_hash({names[idx], " iv"}, EXPECTED_IV, hash);
      end
      @(posedge clk);
      #2;
      start   = 1'b1;
      block   = blocks[idx];
      counter = ctrs[idx];
      @(negedge clk);
      check_bit({names[idx], " idle busy"}, 1'b0, busy);
      @(posedge clk);
      #2 start = 1'b0;
      edges = 0;
      // count edges after the one that sampled start
      @(negedge clk);
      while (done !== 1'b1) begin
         // busy through the half-rounds, low in the feed-forward cycle
         check_bit({names[idx], " busy in run"}, edges < 2 * NUM_ROUNDS, busy);
         edges++;
         @(negedge clk);
      end
      check_count({names[idx], " latency"}, 2 * NUM_ROUNDS + 1, edges);
      check_bit({names[idx], " busy at done"}, 1'b0, busy);
      check_hash(names[idx], expected[idx], hash);
      @(negedge clk);
      assert (done === 1'b0) else begin
         protocol_errors++;
         $display("%s: done_o stayed high for more than one cycle", names[idx]);
      end
      check_hash({names[idx], " hold"}, expected[idx], hash);
   endtask

   initial begin
      chain_t prev;
      void'($urandom(SEED));
      rst_n    = 1'b0;
      init     = 1'b0;
      start    = 1'b0;
      block    = '0;
      counter  = '0;

      // expected chain starts from the zero hash left by reset
      prev = '0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         for (int w = 0; w < 16; w++) begin
            blocks[i][w] = $urandom();
         end
         ctrs[i]     = {$urandom(), $urandom()};
         expected[i] = compress_block(init_tab[i] ? EXPECTED_IV : prev, blocks[i], ctrs[i],
                                      NUM_ROUNDS);
         prev        = expected[i];
      end

      repeat (10) @(posedge clk);
      #2 rst_n = 1'b1;
      @(negedge clk);
      check_bit("reset busy", 1'b0, busy);
      check_bit("reset done", 1'b0, done);
      check_hash("reset hash", '0, hash);

      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end

      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+.
blake_types_pkg.sv
blake_const_pkg.sv
blake_g.sv
blake_msg_sched.sv
blake_state_regs.sv
blake_chain_hash.sv
blake_core_top.sv
blake_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal --top-module blake_tb -f verilog.f --Mdir obj_dir -o blake_sim

run: compile
	./obj_dir/blake_sim > sim.log 2>&1; cat sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
